/* design/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// register file and address width
`define LSU_XLEN 32
`define LSU_REG_W 5

// ------------------------------
// bus geometry, 64-bit AXI data path
// ------------------------------
`define LSU_BUS_W 64
`define LSU_STRB_W 8
`define LSU_BEAT_BYTES 8
// byte offset inside one beat
`define LSU_OFS_W 3
// AXI size field
`define LSU_SIZE_W 3

`endif

/* design/lsu_pkg.sv */
package lsu_pkg;

	// memory opcodes, loads first then stores
	typedef enum logic [2:0] {
		LB  = 3'd0,
		LH  = 3'd1,
		LW  = 3'd2,
		LBU = 3'd3,
		LHU = 3'd4,
		SB  = 3'd5,
		SH  = 3'd6,
		SW  = 3'd7
	} lsu_op_e;

	// read FSM, RD_NEXT issues the second AR of a split load
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA,
		RD_NEXT
	} rd_state_e;

	// write FSM, WR_NEXT issues the second AW of a split store
	typedef enum logic [2:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP,
		WR_NEXT
	} wr_state_e;

endpackage

/* design/lsu_lane_plan.sv */
`include "lsu_settings.svh"

module lsu_lane_plan import lsu_pkg::*; (
	input  lsu_op_e                  op,
	input  logic [`LSU_XLEN-1:0]     addr,
	input  logic [`LSU_XLEN-1:0]     wdata,
	output logic [`LSU_XLEN-1:0]     beat0_addr,
	output logic [`LSU_XLEN-1:0]     beat1_addr,
	output logic [`LSU_STRB_W-1:0]   beat0_strb,
	output logic [`LSU_STRB_W-1:0]   beat1_strb,
	output logic                     split,
	output logic [`LSU_BUS_W-1:0]    bus_wdata,
	output logic [`LSU_SIZE_W-1:0]   size
);

	logic [`LSU_OFS_W-1:0]      ofs;
	logic [3:0]                 byte_mask;
	logic [2*`LSU_STRB_W-1:0]   strb_wide;
	logic [`LSU_BUS_W-1:0]      data_wide;
	logic [2*`LSU_BUS_W-1:0]    data_dbl;
	logic [5:0]                 bit_ofs;

	assign ofs     = addr[`LSU_OFS_W-1:0];
	assign bit_ofs = {ofs, 3'b000};

	// ------------------------------
	// access width
	// ------------------------------
	always_comb begin
		case (op)
			LB, LBU, SB: begin
				byte_mask = 4'b0001;
				size      = 3'd0;
			end
			LH, LHU, SH: begin
				byte_mask = 4'b0011;
				size      = 3'd1;
			end
			default: begin
				byte_mask = 4'b1111;
				size      = 3'd2;
			end
		endcase
	end

	// ------------------------------
	// beat addresses
	// ------------------------------
	// both beats aligned to 8 bytes
	assign beat0_addr = {addr[`LSU_XLEN-1:`LSU_OFS_W], {`LSU_OFS_W{1'b0}}};
	assign beat1_addr = beat0_addr + `LSU_BEAT_BYTES;

	// ------------------------------
	// strobes
	// ------------------------------
	// mask placed at the byte offset, the upper half is what spills over
	assign strb_wide  = {{(2*`LSU_STRB_W-4){1'b0}}, byte_mask} << ofs;
	assign beat0_strb = strb_wide[`LSU_STRB_W-1:0];
	assign beat1_strb = strb_wide[2*`LSU_STRB_W-1:`LSU_STRB_W];
	assign split      = |beat1_strb;

	// ------------------------------
	// store data lanes
	// ------------------------------
	// rotate left across the beat, spilled bytes land in the low lanes
	// and go out with the second beat
	assign data_wide = {{(`LSU_BUS_W-`LSU_XLEN){1'b0}}, wdata};
	assign data_dbl  = {data_wide, data_wide} << bit_ofs;
	assign bus_wdata = data_dbl[2*`LSU_BUS_W-1:`LSU_BUS_W];

endmodule

/* design/lsu_req_stage.sv */
`include "lsu_settings.svh"

module lsu_req_stage import lsu_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     req_valid,
	input  lsu_op_e                  req_op,
	input  logic [`LSU_XLEN-1:0]     req_addr,
	input  logic [`LSU_XLEN-1:0]     req_wdata,
	input  logic [`LSU_REG_W-1:0]    req_rd,
	input  logic                     seq_done,
	output logic                     req_ready,
	output logic                     busy,
	output logic                     is_load,
	output lsu_op_e                  cur_op,
	output logic [`LSU_REG_W-1:0]    cur_rd,
	output logic [`LSU_OFS_W-1:0]    addr_low,
	output logic [`LSU_XLEN-1:0]     beat0_addr,
	output logic [`LSU_XLEN-1:0]     beat1_addr,
	output logic [`LSU_STRB_W-1:0]   beat0_strb,
	output logic [`LSU_STRB_W-1:0]   beat1_strb,
	output logic                     split,
	output logic [`LSU_BUS_W-1:0]    bus_wdata,
	output logic [`LSU_SIZE_W-1:0]   size
);

	logic                  accept;
	logic [`LSU_XLEN-1:0]  cur_addr;
	logic [`LSU_XLEN-1:0]  cur_wdata;

	// a new request may enter in the cycle the sequencer finishes
	assign req_ready = !busy || seq_done;
	assign accept    = req_valid && req_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (accept) begin
			busy <= 1'b1;
		end else if (seq_done) begin
			busy <= 1'b0;
		end
	end

	// held request
	always_ff @(posedge clock) begin
		if (accept) begin
			cur_op    <= req_op;
			cur_addr  <= req_addr;
			cur_wdata <= req_wdata;
			cur_rd    <= req_rd;
		end
	end

	assign is_load  = cur_op inside {LB, LH, LW, LBU, LHU};
	assign addr_low = cur_addr[`LSU_OFS_W-1:0];

	lsu_lane_plan u_lane_plan (
		.op         (cur_op),
		.addr       (cur_addr),
		.wdata      (cur_wdata),
		.beat0_addr (beat0_addr),
		.beat1_addr (beat1_addr),
		.beat0_strb (beat0_strb),
		.beat1_strb (beat1_strb),
		.split      (split),
		.bus_wdata  (bus_wdata),
		.size       (size)
	);

endmodule

/* design/lsu_read_seq.sv */
`include "lsu_settings.svh"

module lsu_read_seq import lsu_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     busy,
	input  logic                     is_load,
	input  logic [`LSU_XLEN-1:0]     beat0_addr,
	input  logic [`LSU_XLEN-1:0]     beat1_addr,
	input  logic                     split,
	input  logic [`LSU_SIZE_W-1:0]   size,
	input  logic                     arready,
	input  logic                     rvalid,
	input  logic [`LSU_BUS_W-1:0]    rdata,
	output logic                     arvalid,
	output logic [`LSU_XLEN-1:0]     araddr,
	output logic [`LSU_SIZE_W-1:0]   arsize,
	output logic                     rready,
	output logic                     seq_done,
	output logic                     merge_fire,
	output logic [`LSU_BUS_W-1:0]    beat0_data,
	output logic [`LSU_BUS_W-1:0]    beat1_data
);

	rd_state_e             state, next;
	logic                  second_q;
	logic                  r_fire;
	logic [`LSU_BUS_W-1:0] first_q;

	assign r_fire = (state == RD_DATA) && rvalid;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RD_IDLE;
		end else begin
			state <= next;
		end
	end

	always_comb begin
		next = state;
		case (state)
			RD_IDLE: if (busy && is_load) next = RD_ADDR;
			RD_ADDR: if (arready) next = RD_DATA;
			RD_NEXT: if (arready) next = RD_DATA;
			RD_DATA: begin
				if (rvalid) begin
					next = (split && !second_q) ? RD_NEXT : RD_IDLE;
				end
			end
			default: next = RD_IDLE;
		endcase
	end

	// marks the second beat of a split load
	always_ff @(posedge clock) begin
		if (reset) begin
			second_q <= 1'b0;
		end else if (r_fire) begin
			second_q <= split && !second_q;
		end
	end

	// first beat kept until the second one arrives
	always_ff @(posedge clock) begin
		if (r_fire && !second_q) begin
			first_q <= rdata;
		end
	end

	assign arvalid = (state == RD_ADDR) || (state == RD_NEXT);
	assign araddr  = second_q ? beat1_addr : beat0_addr;
	assign arsize  = size;
	assign rready  = (state == RD_DATA);

	assign seq_done   = r_fire && (!split || second_q);
	assign merge_fire = seq_done;
	assign beat0_data = second_q ? first_q : rdata;
	assign beat1_data = rdata;

endmodule

/* design/lsu_write_seq.sv */
`include "lsu_settings.svh"

module lsu_write_seq import lsu_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     busy,
	input  logic                     is_load,
	input  logic [`LSU_XLEN-1:0]     beat0_addr,
	input  logic [`LSU_XLEN-1:0]     beat1_addr,
	input  logic [`LSU_STRB_W-1:0]   beat0_strb,
	input  logic [`LSU_STRB_W-1:0]   beat1_strb,
	input  logic                     split,
	input  logic [`LSU_SIZE_W-1:0]   size,
	input  logic [`LSU_BUS_W-1:0]    bus_wdata,
	input  logic                     awready,
	input  logic                     wready,
	input  logic                     bvalid,
	output logic                     awvalid,
	output logic [`LSU_XLEN-1:0]     awaddr,
	output logic [`LSU_SIZE_W-1:0]   awsize,
	output logic                     wvalid,
	output logic [`LSU_BUS_W-1:0]    wdata,
	output logic [`LSU_STRB_W-1:0]   wstrb,
	output logic                     wlast,
	output logic                     bready,
	output logic                     seq_done
);

	wr_state_e state, next;
	logic      second_q;
	logic      b_fire;

	assign b_fire = (state == WR_RESP) && bvalid;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= WR_IDLE;
		end else begin
			state <= next;
		end
	end

	// AW, then W, then B for each beat
	always_comb begin
		next = state;
		case (state)
			WR_IDLE: if (busy && !is_load) next = WR_ADDR;
			WR_ADDR: if (awready) next = WR_DATA;
			WR_NEXT: if (awready) next = WR_DATA;
			WR_DATA: if (wready) next = WR_RESP;
			WR_RESP: begin
				if (bvalid) begin
					next = (split && !second_q) ? WR_NEXT : WR_IDLE;
				end
			end
			default: next = WR_IDLE;
		endcase
	end

	// set while the second beat of a split store is on the bus
	always_ff @(posedge clock) begin
		if (reset) begin
			second_q <= 1'b0;
		end else if (b_fire) begin
			second_q <= split && !second_q;
		end
	end

	assign awvalid = (state == WR_ADDR) || (state == WR_NEXT);
	assign awaddr  = second_q ? beat1_addr : beat0_addr;
	assign awsize  = size;

	// same rotated data for both beats, strobes pick the lanes
	assign wvalid = (state == WR_DATA);
	assign wdata  = bus_wdata;
	assign wstrb  = second_q ? beat1_strb : beat0_strb;
	assign wlast  = wvalid;

	assign bready   = (state == WR_RESP);
	assign seq_done = b_fire && (!split || second_q);

endmodule

/* design/lsu_load_merge.sv */
`include "lsu_settings.svh"

module lsu_load_merge import lsu_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     merge_fire,
	input  lsu_op_e                  cur_op,
	input  logic [`LSU_REG_W-1:0]    cur_rd,
	input  logic [`LSU_OFS_W-1:0]    addr_low,
	input  logic [`LSU_BUS_W-1:0]    beat0_data,
	input  logic [`LSU_BUS_W-1:0]    beat1_data,
	output logic                     wb_valid,
	output logic [`LSU_REG_W-1:0]    wb_rd,
	output logic [`LSU_XLEN-1:0]     wb_data
);

	logic [2*`LSU_BUS_W-1:0] joined;
	logic [2*`LSU_BUS_W-1:0] shifted;
	logic [`LSU_XLEN-1:0]    picked;
	logic [`LSU_XLEN-1:0]    load_val;

	// second beat sits above the first, little endian
	assign joined  = {beat1_data, beat0_data};
	assign shifted = joined >> {addr_low, 3'b000};
	assign picked  = shifted[`LSU_XLEN-1:0];

	always_comb begin
		case (cur_op)
			LB:      load_val = {{24{picked[7]}}, picked[7:0]};
			LH:      load_val = {{16{picked[15]}}, picked[15:0]};
			LBU:     load_val = {24'b0, picked[7:0]};
			LHU:     load_val = {16'b0, picked[15:0]};
			default: load_val = picked;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= merge_fire;
		end
	end

	// result register
	always_ff @(posedge clock) begin
		if (merge_fire) begin
			wb_data <= load_val;
			wb_rd   <= cur_rd;
		end
	end

endmodule

/* design/lsu_top.sv */
`include "lsu_settings.svh"

module lsu_top import lsu_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	// request side
	input  logic                     req_valid,
	input  lsu_op_e                  req_op,
	input  logic [`LSU_XLEN-1:0]     req_addr,
	input  logic [`LSU_XLEN-1:0]     req_wdata,
	input  logic [`LSU_REG_W-1:0]    req_rd,
	output logic                     req_ready,
	// write-back side
	output logic                     wb_valid,
	output logic [`LSU_REG_W-1:0]    wb_rd,
	output logic [`LSU_XLEN-1:0]     wb_data,
	output logic                     store_done,
	// AXI write channels
	output logic                     awvalid,
	input  logic                     awready,
	output logic [`LSU_XLEN-1:0]     awaddr,
	output logic [`LSU_SIZE_W-1:0]   awsize,
	output logic                     wvalid,
	input  logic                     wready,
	output logic [`LSU_BUS_W-1:0]    wdata,
	output logic [`LSU_STRB_W-1:0]   wstrb,
	output logic                     wlast,
	input  logic                     bvalid,
	output logic                     bready,
	input  logic [1:0]               bresp,
	// AXI read channels
	output logic                     arvalid,
	input  logic                     arready,
	output logic [`LSU_XLEN-1:0]     araddr,
	output logic [`LSU_SIZE_W-1:0]   arsize,
	input  logic                     rvalid,
	output logic                     rready,
	input  logic [`LSU_BUS_W-1:0]    rdata,
	input  logic [1:0]               rresp
);

	logic                    busy, is_load, split, seq_done;
	logic                    rd_done, wr_done, merge_fire;
	lsu_op_e                 cur_op;
	logic [`LSU_REG_W-1:0]   cur_rd;
	logic [`LSU_OFS_W-1:0]   addr_low;
	logic [`LSU_XLEN-1:0]    beat0_addr, beat1_addr;
	logic [`LSU_STRB_W-1:0]  beat0_strb, beat1_strb;
	logic [`LSU_BUS_W-1:0]   bus_wdata, beat0_data, beat1_data;
	logic [`LSU_SIZE_W-1:0]  size;

	// only one sequencer is active for a given request
	assign seq_done   = rd_done | wr_done;
	assign store_done = wr_done;

	lsu_req_stage u_req (
		.clock, .reset, .req_valid, .req_op, .req_addr, .req_wdata, .req_rd,
		.seq_done, .req_ready, .busy, .is_load, .cur_op, .cur_rd, .addr_low,
		.beat0_addr, .beat1_addr, .beat0_strb, .beat1_strb, .split,
		.bus_wdata, .size
	);

	lsu_read_seq u_rd (
		.clock, .reset, .busy, .is_load, .beat0_addr, .beat1_addr, .split,
		.size, .arready, .rvalid, .rdata, .arvalid, .araddr, .arsize,
		.rready, .seq_done(rd_done), .merge_fire, .beat0_data, .beat1_data
	);

	lsu_write_seq u_wr (
		.clock, .reset, .busy, .is_load, .beat0_addr, .beat1_addr,
		.beat0_strb, .beat1_strb, .split, .size, .bus_wdata, .awready,
		.wready, .bvalid, .awvalid, .awaddr, .awsize, .wvalid, .wdata,
		.wstrb, .wlast, .bready, .seq_done(wr_done)
	);

	lsu_load_merge u_merge (
		.clock, .reset, .merge_fire, .cur_op, .cur_rd, .addr_low,
		.beat0_data, .beat1_data, .wb_valid, .wb_rd, .wb_data
	);

endmodule

/* verif/lsu_assertions.sv */
`include "lsu_settings.svh"

module lsu_assertions import lsu_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     arvalid,
	input  logic                     arready,
	input  logic [`LSU_XLEN-1:0]     araddr,
	input  logic                     awvalid,
	input  logic                     awready,
	input  logic [`LSU_XLEN-1:0]     awaddr,
	input  logic                     wvalid,
	input  logic                     wready,
	input  logic [`LSU_BUS_W-1:0]    wdata,
	input  logic [`LSU_STRB_W-1:0]   wstrb,
	input  logic                     rvalid,
	input  logic                     rready,
	input  logic                     bvalid,
	input  logic                     bready,
	input  logic                     wb_valid,
	input  logic                     store_done,
	input  rd_state_e                rd_state,
	input  wr_state_e                wr_state
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// a valid holds with its payload until the transfer
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			$error("arvalid dropped or araddr changed before the AR transfer");
			fail_count++;
		end

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			$error("awvalid dropped or awaddr changed before the AW transfer");
			fail_count++;
		end

	w_hold: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else begin
			$error("wvalid dropped or W payload changed before the W transfer");
			fail_count++;
		end

	// rready from the AR transfer up to the R transfer
	r_window: assert property (@(posedge clock) disable iff (reset)
		((arvalid && arready) || (rready && !rvalid)) |=> rready)
		else begin
			$error("rready not held from the AR transfer to the R transfer");
			fail_count++;
		end

	// bready from the W transfer up to the B transfer
	b_window: assert property (@(posedge clock) disable iff (reset)
		((wvalid && wready) || (bready && !bvalid)) |=> bready)
		else begin
			$error("bready not held from the W transfer to the B transfer");
			fail_count++;
		end

	// only one sequencer works at a time
	one_seq: assert property (@(posedge clock) disable iff (reset)
		!(rd_state != RD_IDLE && wr_state != WR_IDLE))
		else begin
			$error("read and write sequencers active together");
			fail_count++;
		end

	// loads and stores never finish together
	one_result: assert property (@(posedge clock) disable iff (reset)
		!(wb_valid && store_done))
		else begin
			$error("wb_valid and store_done in the same cycle");
			fail_count++;
		end

endmodule

bind lsu_top lsu_assertions i_asrt (
	.clock      (clock),
	.reset      (reset),
	.arvalid    (arvalid),
	.arready    (arready),
	.araddr     (araddr),
	.awvalid    (awvalid),
	.awready    (awready),
	.awaddr     (awaddr),
	.wvalid     (wvalid),
	.wready     (wready),
	.wdata      (wdata),
	.wstrb      (wstrb),
	.rvalid     (rvalid),
	.rready     (rready),
	.bvalid     (bvalid),
	.bready     (bready),
	.wb_valid   (wb_valid),
	.store_done (store_done),
	.rd_state   (u_rd.state),
	.wr_state   (u_wr.state)
);

/* verif/lsu_checker.sv */
`include "lsu_settings.svh"

module lsu_checker import lsu_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     req_valid,
	input  logic                     req_ready,
	input  lsu_op_e                  req_op,
	input  logic [`LSU_XLEN-1:0]     req_addr,
	input  logic [`LSU_XLEN-1:0]     req_wdata,
	input  logic [`LSU_REG_W-1:0]    req_rd,
	input  logic                     arvalid,
	input  logic                     arready,
	input  logic [`LSU_XLEN-1:0]     araddr,
	input  logic [`LSU_SIZE_W-1:0]   arsize,
	input  logic                     rvalid,
	input  logic                     rready,
	input  logic                     awvalid,
	input  logic                     awready,
	input  logic [`LSU_XLEN-1:0]     awaddr,
	input  logic [`LSU_SIZE_W-1:0]   awsize,
	input  logic                     wvalid,
	input  logic                     wready,
	input  logic [`LSU_STRB_W-1:0]   wstrb,
	input  logic                     wlast,
	input  logic                     bvalid,
	input  logic                     bready,
	input  logic                     wb_valid,
	input  logic [`LSU_REG_W-1:0]    wb_rd,
	input  logic [`LSU_XLEN-1:0]     wb_data,
	input  logic                     store_done,
	output int                       done_count,
	output int                       mismatch_count,
	output int                       other_count
);

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		lsu_op_e                op;
		logic [`LSU_XLEN-1:0]   addr;
		logic [`LSU_XLEN-1:0]   wdata;
		logic [`LSU_REG_W-1:0]  rd;
	} req_t;

	logic [7:0] model [0:255];
	req_t       bus_q[$];
	req_t       done_q[$];
	req_t       head;
	req_t       incoming;
	int         n_ar, n_aw, n_r, n_b, strb_sum;
	logic       idle_checked;

	function automatic logic [7:0] init_byte(int i);
		logic [7:0] a;
		a = i[7:0];
		return (a * 8'h1d) ^ 8'h5a;
	endfunction

	function automatic int width_of(lsu_op_e op);
		case (op)
			LB, LBU, SB: return 1;
			LH, LHU, SH: return 2;
			default:     return 4;
		endcase
	endfunction

	// AXI size is log2 of the access width in bytes
	function automatic logic [2:0] axsize_of(lsu_op_e op);
		case (width_of(op))
			1:       return 3'd0;
			2:       return 3'd1;
			default: return 3'd2;
		endcase
	endfunction

	function automatic bit is_load_op(lsu_op_e op);
		return op == LB || op == LH || op == LW || op == LBU || op == LHU;
	endfunction

	// two beats when the bytes run past the end of the 8-byte beat
	function automatic int beats_of(req_t r);
		return (int'(r.addr[2:0]) + width_of(r.op) > 8) ? 2 : 1;
	endfunction

	function automatic logic [31:0] beat_addr(req_t r, int k);
		return {r.addr[31:3], 3'b000} + 32'(8 * k);
	endfunction

	function automatic logic [31:0] expect_load(req_t r);
		logic [31:0] raw;
		logic [7:0]  idx;
		raw = '0;
		for (int i = 0; i < width_of(r.op); i++) begin
			idx = r.addr[7:0] + 8'(i);
			raw[8*i +: 8] = model[idx];
		end
		case (r.op)
			LB:      return {{24{raw[7]}}, raw[7:0]};
			LH:      return {{16{raw[15]}}, raw[15:0]};
			default: return raw;
		endcase
	endfunction

	task automatic apply_store(req_t r);
		logic [7:0] idx;
		for (int i = 0; i < width_of(r.op); i++) begin
			idx = r.addr[7:0] + 8'(i);
			model[idx] = r.wdata[8*i +: 8];
		end
	endtask

	task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
		$display("MISMATCH %s expected %0h actual %0h at %0t", name, exp, act, $time);
		mismatch_count++;
	endtask

	task automatic report_other(string what);
		$display("ERROR %s at %0t", what, $time);
		other_count++;
	endtask

	initial begin
		for (int i = 0; i < 256; i++) model[i] = init_byte(i);
		done_count     = 0;
		mismatch_count = 0;
		other_count    = 0;
		idle_checked   = 1'b0;
	end

	task automatic clear_beats();
		n_ar     = 0;
		n_aw     = 0;
		n_r      = 0;
		n_b      = 0;
		strb_sum = 0;
	endtask

	always @(posedge clock) begin
		if (reset) begin
			clear_beats();
		end else begin
			// outputs right after reset
			if (!idle_checked) begin
				if (!req_ready || arvalid || awvalid || wvalid || rready || bready ||
						wb_valid || store_done)
					report_other("outputs not idle after reset");
				idle_checked = 1'b1;
			end

			// -------- bus side --------
			if (arvalid && arready) begin
				if (bus_q.size() == 0 || !is_load_op(bus_q[0].op)) begin
					report_other("AR transfer without a load in progress");
				end else begin
					if (araddr !== beat_addr(bus_q[0], n_ar))
						report_mismatch("ar_addr", beat_addr(bus_q[0], n_ar), araddr);
					if (arsize !== axsize_of(bus_q[0].op))
						report_mismatch("ar_size", axsize_of(bus_q[0].op), arsize);
					n_ar++;
				end
			end
			if (awvalid && awready) begin
				if (bus_q.size() == 0 || is_load_op(bus_q[0].op)) begin
					report_other("AW transfer without a store in progress");
				end else begin
					if (awaddr !== beat_addr(bus_q[0], n_aw))
						report_mismatch("aw_addr", beat_addr(bus_q[0], n_aw), awaddr);
					if (awsize !== axsize_of(bus_q[0].op))
						report_mismatch("aw_size", axsize_of(bus_q[0].op), awsize);
					n_aw++;
				end
			end
			if (wvalid && wready) begin
				strb_sum += $countones(wstrb);
				if (wlast !== 1'b1) report_mismatch("wlast", 1, wlast);
			end

			if (rvalid && rready && bus_q.size() > 0) begin
				n_r++;
				if (n_r == beats_of(bus_q[0])) begin
					if (n_ar != n_r) report_mismatch("ar_count", n_r, n_ar);
					void'(bus_q.pop_front());
					clear_beats();
				end
			end
			if (bvalid && bready && bus_q.size() > 0) begin
				n_b++;
				if (n_b == beats_of(bus_q[0])) begin
					head = bus_q.pop_front();
					if (n_aw != n_b) report_mismatch("aw_count", n_b, n_aw);
					if (strb_sum != width_of(head.op))
						report_mismatch("strb_bits", width_of(head.op), strb_sum);
					apply_store(head);
					clear_beats();
				end
			end

			// -------- results, in request order --------
			if (wb_valid) begin
				if (done_q.size() == 0 || !is_load_op(done_q[0].op)) begin
					report_other("write-back with no load outstanding");
				end else begin
					head = done_q.pop_front();
					if (wb_data !== expect_load(head))
						report_mismatch("load_data", expect_load(head), wb_data);
					if (wb_rd !== head.rd) report_mismatch("wb_rd", head.rd, wb_rd);
				end
				done_count++;
			end
			if (store_done) begin
				if (done_q.size() == 0 || is_load_op(done_q[0].op))
					report_other("store_done with no store outstanding");
				else
					void'(done_q.pop_front());
				done_count++;
			end

			if (req_valid && req_ready) begin
				incoming.op    = req_op;
				incoming.addr  = req_addr;
				incoming.wdata = req_wdata;
				incoming.rd    = req_rd;
				bus_q.push_back(incoming);
				done_q.push_back(incoming);
			end
		end
	end

endmodule

/* verif/lsu_tb.sv */
`include "lsu_settings.svh"

module lsu_tb import lsu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_REQ      = 300;
	localparam int WAIT_LIMIT = 1000;
	localparam int IDLE_LIMIT = 50000;

	logic clock, reset;
	logic req_valid, req_ready;
	lsu_op_e req_op;
	logic [`LSU_XLEN-1:0] req_addr, req_wdata;
	logic [`LSU_REG_W-1:0] req_rd;
	logic wb_valid, store_done;
	logic [`LSU_REG_W-1:0] wb_rd;
	logic [`LSU_XLEN-1:0] wb_data;
	logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [`LSU_XLEN-1:0] awaddr, araddr;
	logic [`LSU_SIZE_W-1:0] awsize, arsize;
	logic [`LSU_BUS_W-1:0] wdata, rdata;
	logic [`LSU_STRB_W-1:0] wstrb;
	logic [1:0] bresp, rresp;
	int done_count, mismatch_count, other_count;

	integer seed;
	int tb_errors;
	logic hung = 1'b0;
	logic run_over = 1'b0;
	logic [7:0] mem [0:255];

	lsu_top i_dut (.*);

	lsu_checker i_chk (
		.clock, .reset, .req_valid, .req_ready, .req_op, .req_addr, .req_wdata, .req_rd,
		.arvalid, .arready, .araddr, .arsize, .rvalid, .rready, .awvalid, .awready,
		.awaddr, .awsize, .wvalid, .wready, .wstrb, .wlast, .bvalid, .bready,
		.wb_valid, .wb_rd, .wb_data,
		.store_done, .done_count, .mismatch_count, .other_count
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic int pick_delay();
		return $unsigned($random(seed)) % 4;
	endfunction

	task automatic note_hang(string what);
		$display("ERROR timeout, %s at %0t", what, $time);
		tb_errors++;
		hung = 1'b1;
	endtask

	function automatic logic [63:0] read_beat(logic [31:0] a);
		logic [63:0] beat;
		for (int i = 0; i < 8; i++) beat[8*i +: 8] = mem[a[7:0] + 8'(i)];
		return beat;
	endfunction

	// AR then R, random delays on both
	task automatic serve_read();
		int t;
		logic [31:0] a;
		t = 0;
		@(posedge clock);
		while (arvalid !== 1'b1) begin
			if (run_over || hung) return;
			t++;
			if (t > IDLE_LIMIT) begin
				note_hang("no read request reached the bus");
				return;
			end
			@(posedge clock);
		end
		repeat (pick_delay()) @(negedge clock);
		@(negedge clock);
		arready = 1'b1;
		a = araddr;
		@(negedge clock);
		arready = 1'b0;
		repeat (pick_delay()) @(negedge clock);
		rvalid = 1'b1;
		rdata  = read_beat(a);
		t = 0;
		@(posedge clock);
		while (!rready) begin
			t++;
			if (t > WAIT_LIMIT) begin
				note_hang("rready never rose");
				return;
			end
			@(posedge clock);
		end
		@(negedge clock);
		rvalid = 1'b0;
	endtask

	// AW, W, then B
	task automatic serve_write();
		int t;
		logic [31:0] a;
		t = 0;
		@(posedge clock);
		while (awvalid !== 1'b1) begin
			if (run_over || hung) return;
			t++;
			if (t > IDLE_LIMIT) begin
				note_hang("no write request reached the bus");
				return;
			end
			@(posedge clock);
		end
		repeat (pick_delay()) @(negedge clock);
		@(negedge clock);
		awready = 1'b1;
		a = awaddr;
		@(negedge clock);
		awready = 1'b0;
		t = 0;
		@(posedge clock);
		while (!wvalid) begin
			t++;
			if (t > WAIT_LIMIT) begin
				note_hang("wvalid never rose");
				return;
			end
			@(posedge clock);
		end
		repeat (pick_delay()) @(negedge clock);
		@(negedge clock);
		wready = 1'b1;
		@(posedge clock);
		for (int i = 0; i < 8; i++)
			if (wstrb[i]) mem[a[7:0] + 8'(i)] = wdata[8*i +: 8];
		@(negedge clock);
		wready = 1'b0;
		repeat (pick_delay()) @(negedge clock);
		bvalid = 1'b1;
		t = 0;
		@(posedge clock);
		while (!bready) begin
			t++;
			if (t > WAIT_LIMIT) begin
				note_hang("bready never rose");
				return;
			end
			@(posedge clock);
		end
		@(negedge clock);
		bvalid = 1'b0;
	endtask

	initial begin
		while (!run_over && !hung) serve_read();
	end

	initial begin
		while (!run_over && !hung) serve_write();
	end

	task automatic send_request(lsu_op_e op, logic [31:0] a, logic [31:0] d, logic [4:0] rd);
		int t;
		req_valid = 1'b1;
		req_op    = op;
		req_addr  = a;
		req_wdata = d;
		req_rd    = rd;
		t = 0;
		@(posedge clock);
		while (!req_ready) begin
			t++;
			if (t > WAIT_LIMIT) begin
				note_hang("request never accepted");
				return;
			end
			@(posedge clock);
		end
		@(negedge clock);
		req_valid = 1'b0;
	endtask

	initial begin
		int t;
		seed      = 32'h6a1635f3;
		tb_errors = 0;
		for (int i = 0; i < 256; i++) mem[i] = i_chk.init_byte(i);
		reset = 1'b1;
		req_valid = 1'b0;
		req_op    = LB;
		req_addr  = '0;
		req_wdata = '0;
		req_rd    = '0;
		{awready, wready, bvalid, arready, rvalid} = '0;
		bresp = 2'b00;
		rresp = 2'b00;
		rdata = '0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		repeat (2) @(negedge clock);

		// random ops over a 256-byte window, any offset
		for (int i = 0; i < N_REQ && !hung; i++) begin
			repeat ($unsigned($random(seed)) % 3) @(negedge clock);
			send_request(lsu_op_e'($unsigned($random(seed)) % 8),
				{24'h0, 8'($random(seed))}, $random(seed), 5'($random(seed)));
		end

		t = 0;
		while (done_count < N_REQ && !hung) begin
			t++;
			if (t > WAIT_LIMIT) note_hang("results missing at the end");
			@(posedge clock);
		end
		repeat (4) @(posedge clock);
		run_over = 1'b1;
		if (done_count != N_REQ) begin
			$display("ERROR %0d results seen for %0d requests", done_count, N_REQ);
			tb_errors++;
		end

		$display("errors: mismatches %0d, checker %0d, testbench %0d, assertions %0d",
			mismatch_count, other_count, tb_errors, i_dut.i_asrt.fail_count);
		if (mismatch_count + other_count + tb_errors + i_dut.i_asrt.fail_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+design
design/lsu_pkg.sv
design/lsu_lane_plan.sv
design/lsu_req_stage.sv
design/lsu_read_seq.sv
design/lsu_write_seq.sv
design/lsu_load_merge.sv
design/lsu_top.sv
verif/lsu_assertions.sv
verif/lsu_checker.sv
verif/lsu_tb.sv
